// ==== logic/vec_pkg.sv ====
package vec_pkg;

    // ------------------------------------------------------------
    // datapath sizes
    // ------------------------------------------------------------
    localparam int word_bits = 32;
    localparam int vlen_bits = 256;
    localparam int num_words = vlen_bits / word_bits;
    localparam int num_lanes = 2;
    localparam int num_steps = num_words / num_lanes;
    // lengths 0 to 32
    localparam int vl_bits   = 6;

    typedef logic [word_bits-1:0]             word_t;
    typedef logic [vlen_bits-1:0]             vreg_t;
    typedef logic [31:0]                      scalar_t;
    typedef logic [vl_bits-1:0]               vl_t;
    typedef logic [$clog2(num_words)-1:0]     word_idx_t;
    typedef logic [word_bits/8-1:0]           byte_en_t;
    typedef logic [1:0]                       sew_t;
    typedef logic [5:0]                       funct6_t;
    typedef logic [1:0]                       opnd_t;

    // element width codes, 3 behaves as 32 bits
    localparam sew_t sew_e8  = 2'd0;
    localparam sew_t sew_e16 = 2'd1;
    localparam sew_t sew_e32 = 2'd2;

    // ------------------------------------------------------------
    // operation and operand codes
    // ------------------------------------------------------------
    localparam funct6_t op_add  = 6'h00;
    localparam funct6_t op_sub  = 6'h02;
    localparam funct6_t op_minu = 6'h04;
    localparam funct6_t op_maxu = 6'h06;
    localparam funct6_t op_and  = 6'h09;
    localparam funct6_t op_or   = 6'h0a;
    localparam funct6_t op_xor  = 6'h0b;

    localparam opnd_t opnd_vv = 2'd0;
    localparam opnd_t opnd_vx = 2'd1;
    localparam opnd_t opnd_vi = 2'd2;

endpackage

// ==== logic/vec_config.sv ====
`timescale 1ns/1ps

module vec_config (
    input  logic             clk,
    input  logic             rst,
    input  logic             cfg,
    input  vec_pkg::scalar_t cfg_avl,
    input  vec_pkg::sew_t    cfg_sew,
    output vec_pkg::vl_t     vl,
    output vec_pkg::sew_t    sew
);

    vec_pkg::vl_t vl_max;
    vec_pkg::vl_t vl_new;

    // longest vector that fits the register at the requested width
    always_comb begin
        case (cfg_sew)
            vec_pkg::sew_e8:  vl_max = vec_pkg::vl_t'(vec_pkg::vlen_bits / 8);
            vec_pkg::sew_e16: vl_max = vec_pkg::vl_t'(vec_pkg::vlen_bits / 16);
            default:          vl_max = vec_pkg::vl_t'(vec_pkg::vlen_bits / 32);
        endcase
    end

    // vl = min(avl, vlmax)
    always_comb begin
        if (cfg_avl > vec_pkg::scalar_t'(vl_max)) begin
            vl_new = vl_max;
        end else begin
            vl_new = vec_pkg::vl_t'(cfg_avl);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vl  <= '0;
            sew <= vec_pkg::sew_e8;
        end else if (cfg) begin
            vl  <= vl_new;
            sew <= cfg_sew;
        end
    end

endmodule

// ==== logic/vec_dispatch.sv ====
`timescale 1ns/1ps

module vec_dispatch (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          execute,
    input  vec_pkg::vl_t                                  vl,
    input  vec_pkg::sew_t                                 sew,
    input  vec_pkg::funct6_t                              funct6,
    input  vec_pkg::opnd_t                                opnd,
    input  logic                                          vm,
    input  vec_pkg::vreg_t                                vs1,
    input  vec_pkg::vreg_t                                vs2,
    input  vec_pkg::vreg_t                                vd_old,
    input  vec_pkg::vreg_t                                v0,
    input  vec_pkg::scalar_t                              rs,
    input  logic [4:0]                                    imm,
    output logic                                          busy,
    output logic [vec_pkg::num_lanes-1:0]                 issue,
    output vec_pkg::word_idx_t [vec_pkg::num_lanes-1:0]   word_idx,
    output vec_pkg::word_t [vec_pkg::num_lanes-1:0]       a,
    output vec_pkg::word_t [vec_pkg::num_lanes-1:0]       b,
    output vec_pkg::word_t [vec_pkg::num_lanes-1:0]       old,
    output vec_pkg::byte_en_t [vec_pkg::num_lanes-1:0]    byte_en,
    output vec_pkg::sew_t                                 lane_sew,
    output vec_pkg::funct6_t                              lane_funct6
);

    typedef enum logic {
        st_idle,
        st_run
    } state_t;

    state_t state;
    // counts issue steps, one extra value covers the lane drain
    logic [2:0] step;

    // operand latch
    vec_pkg::vl_t     vl_q;
    vec_pkg::sew_t    sew_q;
    vec_pkg::funct6_t funct6_q;
    vec_pkg::opnd_t   opnd_q;
    logic             vm_q;
    vec_pkg::vreg_t   vs1_q;
    vec_pkg::vreg_t   vs2_q;
    vec_pkg::vreg_t   old_q;
    vec_pkg::vreg_t   v0_q;
    vec_pkg::scalar_t rs_q;
    logic [4:0]       imm_q;

    vec_pkg::word_t   b_rep;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    step <= '0;
                    if (execute) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    step <= step + 3'd1;
                    if (step == 3'(vec_pkg::num_steps)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && execute) begin
            vl_q     <= vl;
            sew_q    <= sew;
            funct6_q <= funct6;
            opnd_q   <= opnd;
            vm_q     <= vm;
            vs1_q    <= vs1;
            vs2_q    <= vs2;
            old_q    <= vd_old;
            v0_q     <= v0;
            rs_q     <= rs;
            imm_q    <= imm;
        end
    end

    assign busy        = (state == st_run);
    assign lane_sew    = sew_q;
    assign lane_funct6 = funct6_q;

    // scalar or sign-extended immediate, repeated at the element width
    always_comb begin : rep_blk
        vec_pkg::word_t src;
        if (opnd_q == vec_pkg::opnd_vi) begin
            src = {{27{imm_q[4]}}, imm_q};
        end else begin
            src = rs_q;
        end
        case (sew_q)
            vec_pkg::sew_e8:  b_rep = {4{src[7:0]}};
            vec_pkg::sew_e16: b_rep = {2{src[15:0]}};
            default:          b_rep = src;
        endcase
    end

    // ------------------------------------------------------------
    // per-lane word select and byte enables
    // ------------------------------------------------------------
    always_comb begin : lane_blk
        logic [4:0] elem;
        for (int l = 0; l < vec_pkg::num_lanes; l++) begin
            issue[l]    = (state == st_run) && (step < 3'(vec_pkg::num_steps));
            word_idx[l] = vec_pkg::word_idx_t'(step * vec_pkg::num_lanes + l);
            a[l]   = vs2_q[word_idx[l]*vec_pkg::word_bits +: vec_pkg::word_bits];
            old[l] = old_q[word_idx[l]*vec_pkg::word_bits +: vec_pkg::word_bits];
            if (opnd_q == vec_pkg::opnd_vv) begin
                b[l] = vs1_q[word_idx[l]*vec_pkg::word_bits +: vec_pkg::word_bits];
            end else begin
                b[l] = b_rep;
            end
            for (int j = 0; j < vec_pkg::word_bits / 8; j++) begin
                // element that owns byte j of this word
                case (sew_q)
                    vec_pkg::sew_e8:  elem = 5'(word_idx[l] * 4 + j);
                    vec_pkg::sew_e16: elem = 5'(word_idx[l] * 2 + j / 2);
                    default:          elem = 5'(word_idx[l]);
                endcase
                byte_en[l][j] = ({1'b0, elem} < vl_q) && (vm_q || v0_q[elem]);
            end
        end
    end

endmodule

// ==== logic/vec_lane.sv ====
`timescale 1ns/1ps

module vec_lane (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue,
    input  vec_pkg::word_idx_t word_idx,
    input  vec_pkg::word_t     a,
    input  vec_pkg::word_t     b,
    input  vec_pkg::word_t     old,
    input  vec_pkg::byte_en_t  byte_en,
    input  vec_pkg::sew_t      sew,
    input  vec_pkg::funct6_t   funct6,
    output logic               out_valid,
    output vec_pkg::word_idx_t out_idx,
    output vec_pkg::word_t     out_word
);

    vec_pkg::word_t calc;
    vec_pkg::word_t merged;

    // one element, operands zero-extended so min/max stay unsigned
    function automatic vec_pkg::word_t elem_op(
        input vec_pkg::word_t   x,
        input vec_pkg::word_t   y,
        input vec_pkg::funct6_t op
    );
        case (op)
            vec_pkg::op_add:  elem_op = x + y;
            vec_pkg::op_sub:  elem_op = x - y;
            vec_pkg::op_minu: elem_op = (x < y) ? x : y;
            vec_pkg::op_maxu: elem_op = (x > y) ? x : y;
            vec_pkg::op_and:  elem_op = x & y;
            vec_pkg::op_or:   elem_op = x | y;
            vec_pkg::op_xor:  elem_op = x ^ y;
            default:          elem_op = x;
        endcase
    endfunction

    // ------------------------------------------------------------
    // packed element compute
    // ------------------------------------------------------------
    // truncating each result keeps carries inside its element
    always_comb begin : calc_blk
        vec_pkg::word_t tmp;
        calc = '0;
        tmp  = '0;
        case (sew)
            vec_pkg::sew_e8: begin
                for (int i = 0; i < 4; i++) begin
                    tmp = elem_op({24'd0, a[i*8 +: 8]}, {24'd0, b[i*8 +: 8]}, funct6);
                    calc[i*8 +: 8] = tmp[7:0];
                end
            end
            vec_pkg::sew_e16: begin
                for (int i = 0; i < 2; i++) begin
                    tmp = elem_op({16'd0, a[i*16 +: 16]}, {16'd0, b[i*16 +: 16]}, funct6);
                    calc[i*16 +: 16] = tmp[15:0];
                end
            end
            default: begin
                calc = elem_op(a, b, funct6);
            end
        endcase
    end

    // inactive and tail bytes keep the old destination
    always_comb begin
        for (int j = 0; j < vec_pkg::word_bits / 8; j++) begin
            merged[j*8 +: 8] = byte_en[j] ? calc[j*8 +: 8] : old[j*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_idx  <= word_idx;
            out_word <= merged;
        end
    end

endmodule

// ==== logic/vec_collect.sv ====
`timescale 1ns/1ps

module vec_collect (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [vec_pkg::num_lanes-1:0]                 lane_valid,
    input  vec_pkg::word_idx_t [vec_pkg::num_lanes-1:0]   lane_idx,
    input  vec_pkg::word_t [vec_pkg::num_lanes-1:0]       lane_word,
    output vec_pkg::vreg_t                                result,
    output logic                                          done
);

    vec_pkg::vreg_t stage_q;
    vec_pkg::vreg_t stage_next;
    logic [3:0]     count;
    logic [3:0]     count_next;

    // drop incoming words into their slots
    always_comb begin : gather_blk
        logic [3:0] added;
        stage_next = stage_q;
        added      = '0;
        for (int l = 0; l < vec_pkg::num_lanes; l++) begin
            if (lane_valid[l]) begin
                stage_next[lane_idx[l]*vec_pkg::word_bits +: vec_pkg::word_bits] = lane_word[l];
                added = added + 4'd1;
            end
        end
        count_next = count + added;
    end

    always_ff @(posedge clk) begin
        stage_q <= stage_next;
    end

    // result only moves on completion
    always_ff @(posedge clk) begin
        if (!rst) begin
            count  <= '0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= 1'b0;
            if (count_next == 4'(vec_pkg::num_words)) begin
                count  <= '0;
                done   <= 1'b1;
                result <= stage_next;
            end else begin
                count <= count_next;
            end
        end
    end

endmodule

// ==== logic/vec_unit.sv ====
`timescale 1ns/1ps

module vec_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             cfg,
    input  vec_pkg::scalar_t cfg_avl,
    input  vec_pkg::sew_t    cfg_sew,
    input  logic             execute,
    input  vec_pkg::funct6_t funct6,
    input  vec_pkg::opnd_t   opnd,
    input  logic             vm,
    input  vec_pkg::vreg_t   vs1,
    input  vec_pkg::vreg_t   vs2,
    input  vec_pkg::vreg_t   vd_old,
    input  vec_pkg::vreg_t   v0,
    input  vec_pkg::scalar_t rs,
    input  logic [4:0]       imm,
    output vec_pkg::vreg_t   result,
    output logic             done,
    output logic             busy
);

    vec_pkg::vl_t     vl;
    vec_pkg::sew_t    sew;
    vec_pkg::sew_t    lane_sew;
    vec_pkg::funct6_t lane_funct6;

    // ------------------------------------------------------------
    // dispatcher to lane wiring
    // ------------------------------------------------------------
    logic [vec_pkg::num_lanes-1:0]               issue;
    vec_pkg::word_idx_t [vec_pkg::num_lanes-1:0] word_idx;
    vec_pkg::word_t [vec_pkg::num_lanes-1:0]     a;
    vec_pkg::word_t [vec_pkg::num_lanes-1:0]     b;
    vec_pkg::word_t [vec_pkg::num_lanes-1:0]     old;
    vec_pkg::byte_en_t [vec_pkg::num_lanes-1:0]  byte_en;

    // lane to collector
    logic [vec_pkg::num_lanes-1:0]               out_valid;
    vec_pkg::word_idx_t [vec_pkg::num_lanes-1:0] out_idx;
    vec_pkg::word_t [vec_pkg::num_lanes-1:0]     out_word;

    vec_config u_config (
        .clk(clk), .rst(rst), .cfg(cfg), .cfg_avl(cfg_avl), .cfg_sew(cfg_sew),
        .vl(vl), .sew(sew)
    );

    vec_dispatch u_dispatch (
        .clk(clk), .rst(rst), .execute(execute), .vl(vl), .sew(sew),
        .funct6(funct6), .opnd(opnd), .vm(vm), .vs1(vs1), .vs2(vs2),
        .vd_old(vd_old), .v0(v0), .rs(rs), .imm(imm), .busy(busy),
        .issue(issue), .word_idx(word_idx), .a(a), .b(b), .old(old),
        .byte_en(byte_en), .lane_sew(lane_sew), .lane_funct6(lane_funct6)
    );

    for (genvar i = 0; i < vec_pkg::num_lanes; i++) begin : g_lane
        vec_lane u_lane (
            .clk(clk), .rst(rst), .issue(issue[i]), .word_idx(word_idx[i]),
            .a(a[i]), .b(b[i]), .old(old[i]), .byte_en(byte_en[i]),
            .sew(lane_sew), .funct6(lane_funct6), .out_valid(out_valid[i]),
            .out_idx(out_idx[i]), .out_word(out_word[i])
        );
    end

    vec_collect u_collect (
        .clk(clk), .rst(rst), .lane_valid(out_valid), .lane_idx(out_idx),
        .lane_word(out_word), .result(result), .done(done)
    );

endmodule

// ==== bench/vec_unit_assertions.sv ====
`timescale 1ns/1ps

module vec_unit_assertions (
    input logic clk,
    input logic rst,
    input logic execute,
    input logic busy,
    input logic done
);

    // done is a one-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // accepted execute, done rises on the fifth edge after it
    done_latency: assert property (@(posedge clk) disable iff (!rst)
        execute && !busy |=> !done [*5] ##1 done)
        else $error("done did not follow the accepted execute by five edges");

    // busy drops on the same edge that raises done
    busy_fall: assert property (@(posedge clk) disable iff (!rst) $fell(busy) |-> done)
        else $error("busy fell without done");
    done_fall: assert property (@(posedge clk) disable iff (!rst) done |-> $fell(busy))
        else $error("done rose while busy did not fall");

endmodule

bind vec_unit vec_unit_assertions u_assertions (
    .clk(clk), .rst(rst), .execute(execute), .busy(busy), .done(done)
);

// ==== bench/vec_unit_checker.sv ====
`timescale 1ns/1ps

module vec_unit_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             cfg,
    input  vec_pkg::scalar_t cfg_avl,
    input  vec_pkg::sew_t    cfg_sew,
    input  logic             execute,
    input  vec_pkg::funct6_t funct6,
    input  vec_pkg::opnd_t   opnd,
    input  logic             vm,
    input  vec_pkg::vreg_t   vs1,
    input  vec_pkg::vreg_t   vs2,
    input  vec_pkg::vreg_t   vd_old,
    input  vec_pkg::vreg_t   v0,
    input  vec_pkg::scalar_t rs,
    input  logic [4:0]       imm,
    input  vec_pkg::vreg_t   result,
    input  logic             done,
    input  logic             busy,
    output int               error_count,
    output int               pending
);

    vec_pkg::vreg_t exp_q[$];
    int             cyc_q[$];
    int             cycle;
    int             vl_m;
    int             ew_m;
    int             lat;
    vec_pkg::vreg_t want;

    // expected register after one instruction, element by element
    function automatic vec_pkg::vreg_t model_result(
        input logic [5:0] op, input logic [1:0] form, input logic m,
        input vec_pkg::vreg_t s1, input vec_pkg::vreg_t s2,
        input vec_pkg::vreg_t sd, input vec_pkg::vreg_t msk,
        input logic [31:0] r, input logic [4:0] i5, input int len, input int ew);
        vec_pkg::vreg_t res;
        vec_pkg::vreg_t emask;
        logic [31:0]    x;
        logic [31:0]    y;
        logic [31:0]    z;
        res   = sd;
        emask = (vec_pkg::vreg_t'(1) << ew) - 1;
        for (int i = 0; i < 256 / ew; i++) begin
            x = 32'((s2 >> (i * ew)) & emask);
            if (form == vec_pkg::opnd_vv) begin
                y = 32'((s1 >> (i * ew)) & emask);
            end else if (form == vec_pkg::opnd_vx) begin
                y = 32'(vec_pkg::vreg_t'(r) & emask);
            end else begin
                y = 32'(vec_pkg::vreg_t'({{27{i5[4]}}, i5}) & emask);
            end
            case (op)
                vec_pkg::op_add:  z = x + y;
                vec_pkg::op_sub:  z = x - y;
                vec_pkg::op_minu: z = (x < y) ? x : y;
                vec_pkg::op_maxu: z = (x > y) ? x : y;
                vec_pkg::op_and:  z = x & y;
                vec_pkg::op_or:   z = x | y;
                vec_pkg::op_xor:  z = x ^ y;
                default:          z = x;
            endcase
            // tail and masked-off elements keep the old value
            if (i < len && (m || msk[i])) begin
                res = (res & ~(emask << (i * ew)))
                    | ((vec_pkg::vreg_t'(z) & emask) << (i * ew));
            end
        end
        return res;
    endfunction

    initial begin
        error_count = 0;
        pending     = 0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            vl_m  = 0;
            ew_m  = 8;
            cycle = 0;
        end else begin
            cycle++;
            if (done) begin
                if (exp_q.size() == 0) begin
                    $display("done pulsed with no instruction outstanding");
                    error_count++;
                end else begin
                    want = exp_q.pop_front();
                    // done rises at the fifth edge and is seen one edge later
                    lat  = cycle - cyc_q.pop_front() - 1;
                    if (result !== want) begin
                        $display("FAILED result: expected %h, got %h", want, result);
                        error_count++;
                    end
                    if (lat != 5) begin
                        $display("FAILED done latency: expected %h, got %h", 5, lat);
                        error_count++;
                    end
                end
            end
            if (execute && !busy) begin
                exp_q.push_back(model_result(funct6, opnd, vm, vs1, vs2, vd_old, v0,
                                             rs, imm, vl_m, ew_m));
                cyc_q.push_back(cycle);
            end
            // new length applies to the next instruction
            if (cfg) begin
                ew_m = (cfg_sew == 0) ? 8 : (cfg_sew == 1) ? 16 : 32;
                vl_m = (cfg_avl > 256 / ew_m) ? 256 / ew_m : int'(cfg_avl);
            end
            pending = exp_q.size();
        end
    end

endmodule

// ==== bench/vec_unit_tb.sv ====
`timescale 1ns/1ps

module vec_unit_tb;

    logic             clk;
    logic             rst;
    logic             cfg;
    vec_pkg::scalar_t cfg_avl;
    vec_pkg::sew_t    cfg_sew;
    logic             execute;
    vec_pkg::funct6_t funct6;
    vec_pkg::opnd_t   opnd;
    logic             vm;
    vec_pkg::vreg_t   vs1;
    vec_pkg::vreg_t   vs2;
    vec_pkg::vreg_t   vd_old;
    vec_pkg::vreg_t   v0;
    vec_pkg::scalar_t rs;
    logic [4:0]       imm;
    vec_pkg::vreg_t   result;
    logic             done;
    logic             busy;
    int               error_count;
    int               pending;
    int               bench_errors;

    vec_unit u_dut (.*);
    vec_unit_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // every word of the vector depends on its index
    function automatic vec_pkg::vreg_t expand_seed(input logic [31:0] seed);
        vec_pkg::vreg_t v;
        for (int i = 0; i < vec_pkg::num_words; i++) begin
            v[i*32 +: 32] = seed ^ (32'h9e3779b9 * i);
        end
        return v;
    endfunction

    task automatic end_run();
        $display("errors: checker %0d, bench %0d", error_count, bench_errors);
        if (error_count == 0 && bench_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // waits, polled at the falling edge
    // ------------------------------------------------------------
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("timeout while waiting for busy to go low");
            bench_errors++;
            end_run();
        end
    endtask

    task automatic catch_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("timeout while waiting for done");
            bench_errors++;
            end_run();
        end
    endtask

    task automatic apply_cfg(input logic [31:0] avl, input logic [1:0] s,
                             input logic [5:0] vl_exp);
        wait_idle();
        cfg     = 1'b1;
        cfg_avl = avl;
        cfg_sew = s;
        @(negedge clk);
        cfg = 1'b0;
        if (u_dut.vl !== vl_exp) begin
            $display("FAILED vl: expected %h, got %h", vl_exp, u_dut.vl);
            bench_errors++;
        end
    endtask

    task automatic run_exec(input logic [5:0] op, input logic [1:0] form, input logic m,
                            input logic [31:0] s1, input logic [31:0] s2,
                            input logic [31:0] sd, input logic [31:0] sm,
                            input logic [31:0] r, input logic [4:0] i5,
                            input logic again);
        wait_idle();
        funct6  = op;
        opnd    = form;
        vm      = m;
        vs1     = expand_seed(s1);
        vs2     = expand_seed(s2);
        vd_old  = expand_seed(sd);
        v0      = expand_seed(sm);
        rs      = r;
        imm     = i5;
        execute = 1'b1;
        @(negedge clk);
        execute = again;
        if (again) begin
            // sent while busy, must never reach the result
            funct6 = vec_pkg::op_sub;
            vs1    = ~vs1;
            vd_old = ~vd_old;
            @(negedge clk);
            execute = 1'b0;
        end
        catch_done();
    endtask

    initial begin : main
        int          fd;
        int          code;
        string       line;
        logic [31:0] f[10];
        bench_errors = 0;
        rst     = 1'b0;
        cfg     = 1'b0;
        cfg_avl = '0;
        cfg_sew = '0;
        execute = 1'b0;
        funct6  = '0;
        opnd    = '0;
        vm      = 1'b0;
        vs1     = '0;
        vs2     = '0;
        vd_old  = '0;
        v0      = '0;
        rs      = '0;
        imm     = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        if (done !== 1'b0 || busy !== 1'b0) begin
            $display("FAILED reset: done %h, busy %h, expected 0", done, busy);
            bench_errors++;
        end
        if (result !== '0) begin
            $display("FAILED result: expected %h, got %h", vec_pkg::vreg_t'(0), result);
            bench_errors++;
        end
        fd = $fopen("bench/vec_stim.txt", "r");
        if (fd == 0) begin
            $display("stimulus file bench/vec_stim.txt could not be opened");
            bench_errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) == "c") begin
                    code = $sscanf(line, "c %h %h %h", f[0], f[1], f[2]);
                    apply_cfg(f[0], f[1][1:0], f[2][5:0]);
                end else if (code > 0 && line.getc(0) == "x") begin
                    code = $sscanf(line, "x %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                   f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    run_exec(f[0][5:0], f[1][1:0], f[2][0], f[3], f[4], f[5], f[6], f[7],
                             f[8][4:0], f[9][0]);
                end
            end
            $fclose(fd);
            wait_idle();
            repeat (2) @(negedge clk);
            if (pending != 0) begin
                $display("%0d accepted instructions never completed", pending);
                bench_errors++;
            end
        end
        end_run();
    end

endmodule

// ==== sources.f ====
logic/vec_pkg.sv
logic/vec_config.sv
logic/vec_dispatch.sv
logic/vec_lane.sv
logic/vec_collect.sv
logic/vec_unit.sv
bench/vec_unit_assertions.sv
bench/vec_unit_checker.sv
bench/vec_unit_tb.sv

// ==== bench/vec_stim.txt ====
# cfg:  c avl sew expected_vl
# exec: x op form vm vs1 vs2 vd_old v0 rs imm again (vectors given as seeds, all hex)
x 00 0 1 13572468 9abcdef0 a5a5a5a5 ffffffff 00000000 00 0
c 00000020 0 20
x 00 0 1 8f7f01ff 81807fff 11223344 00000000 00000000 00 0
x 02 0 1 0180ff7f 02017f80 55667788 00000000 00000000 00 0
x 04 0 1 f00f8001 0ff07f02 99aabbcc 00000000 00000000 00 0
x 06 0 1 f00f8001 0ff07f02 ddeeff00 00000000 00000000 00 0
x 09 0 1 3c3c3c3c 0ff00ff0 12121212 00000000 00000000 00 0
x 0a 0 1 3c3c3c3c 0ff00ff0 34343434 00000000 00000000 00 0
x 0b 0 1 3c3c3c3c 0ff00ff0 56565656 00000000 00000000 00 0
c 00000011 1 10
x 00 0 1 ffff8000 00018001 0badf00d 00000000 00000000 00 0
x 02 0 1 00017fff 0002ffff 1badb002 00000000 00000000 00 0
x 04 0 1 8000ffff 7fff0001 cafe0123 00000000 00000000 00 0
x 06 0 1 8000ffff 7fff0001 0123cafe 00000000 00000000 00 0
x 09 0 1 f0f0aaaa ff0055ff 77777777 00000000 00000000 00 0
x 0a 0 1 f0f0aaaa ff0055ff 88888888 00000000 00000000 00 0
x 0b 0 1 f0f0aaaa ff0055ff 99999999 00000000 00000000 00 0
c 00000040 2 08
x 00 0 1 ffffffff 00000002 deadbeef 00000000 00000000 00 0
x 02 0 1 00000001 00000000 feedface 00000000 00000000 00 0
x 04 0 1 80000000 7fffffff 10203040 00000000 00000000 00 0
x 06 0 1 80000000 7fffffff 50607080 00000000 00000000 00 0
x 09 0 1 12345678 fedcba98 a0b0c0d0 00000000 00000000 00 0
x 0a 0 1 12345678 fedcba98 e0f00010 00000000 00000000 00 0
x 0b 0 1 12345678 fedcba98 20304050 00000000 00000000 00 0
x 00 2 1 00000000 00000003 6b6b6b6b 00000000 00000000 1b 0
x 04 1 1 00000000 fffffffe 4c4c4c4c 00000000 7ffffffe 00 0
c 000000ff 0 20
x 02 2 1 00000000 0f1e2d3c 3a3a3a3a 00000000 00000000 10 0
x 06 1 1 00000000 f00ff00f 5d5d5d5d 00000000 000000f3 00 0
c 00000013 0 13
x 00 0 0 c3c3c3c3 71625344 e7e7e7e7 5a3c0ff1 00000000 00 0
c 00000100 1 10
x 06 2 1 00000000 fffd0005 2b2b2b2b 00000000 00000000 1e 0
x 0a 0 0 0f0f0f0f 30303030 6e6e6e6e 0000c3a5 00000000 00 1
c 00000005 3 05
x 0b 1 0 00000000 a5a55a5a 19191919 000000b2 0f0ff0f0 00 1
